// File: design/loader_pkg.sv
`default_nettype none

package loader_pkg;

    // Host side
    parameter int addr_w = 64;
    parameter int size_w = 13;
    parameter int beat_w = 512;

    // Local memory side
    parameter int word_w = 32;
    parameter int quad_w = 128;
    parameter int words_per_beat = beat_w / word_w;
    parameter int quads_per_beat = beat_w / quad_w;

    // Fetch order of the four segments
    typedef enum logic [1:0] {
        seg_cp,
        seg_rt,
        seg_const,
        seg_tri
    } segment_t;

    typedef struct packed {
        logic              req;
        logic [size_w-1:0] size;
        logic [addr_w-1:0] addr;
    } desc_t;

    // Lane 0 sits in the low bits of either view
    typedef union packed {
        logic [words_per_beat-1:0][word_w-1:0] words;
        logic [quads_per_beat-1:0][quad_w-1:0] quads;
    } beat_t;

    typedef struct packed {
        logic        wr_en;
        logic [15:0] wr_addr;
        logic [63:0] wr_data;
    } mmio_wr_t;

    typedef struct packed {
        logic              go;
        logic              pop;
        logic [addr_w-1:0] addr;
        logic [size_w-1:0] size;
    } dma_rd_req_t;

    typedef struct packed {
        logic  empty;
        logic  done;
        beat_t data;
    } dma_rd_rsp_t;

    typedef struct packed {
        logic [3:0]        we;
        logic [word_w-1:0] data_32;
        logic [quad_w-1:0] data_128;
    } mem_wr_t;

endpackage

`default_nettype wire

// File: design/desc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module desc_regs
    import loader_pkg::*;
#(
    parameter int size_w = loader_pkg::size_w
) (
    input  logic        clk,
    input  logic        rst_n,
    input  mmio_wr_t    mmio,
    input  logic        fetch_done,
    output desc_t [3:0] desc,
    output logic        start
);

    typedef enum logic [2:0] {
        cap_cp,
        cap_rt,
        cap_const,
        cap_tri,
        running
    } cap_state_t;

    cap_state_t        state;
    cap_state_t        state_nxt;
    logic              accept;
    logic              desc_wr;
    segment_t          wr_seg;
    logic [size_w-1:0] wr_size;

    // Bit 1 set means not a descriptor write
    assign accept = mmio.wr_en && !mmio.wr_addr[1];

    // CP always fetches a single beat
    assign wr_size = (wr_seg == seg_cp) ? size_w'(1) : mmio.wr_addr[2 +: size_w];

    always_comb begin
        state_nxt = state;
        desc_wr = 1'b0;
        wr_seg = seg_cp;
        case (state)
            cap_cp: begin
                // A new set only opens with a requested CP
                if (accept && mmio.wr_addr[15]) begin
                    desc_wr = 1'b1;
                    state_nxt = cap_rt;
                end
            end
            cap_rt: begin
                wr_seg = seg_rt;
                if (accept) begin
                    desc_wr = 1'b1;
                    state_nxt = cap_const;
                end
            end
            cap_const: begin
                wr_seg = seg_const;
                if (accept) begin
                    desc_wr = 1'b1;
                    state_nxt = cap_tri;
                end
            end
            cap_tri: begin
                wr_seg = seg_tri;
                if (accept) begin
                    desc_wr = 1'b1;
                    state_nxt = running;
                end
            end
            default: begin
                // Writes ignored until the fetch completes
                if (fetch_done) begin
                    state_nxt = cap_cp;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cap_cp;
            start <= 1'b0;
        end else begin
            state <= state_nxt;
            start <= desc_wr && (wr_seg == seg_tri);
        end
    end

    always_ff @(posedge clk) begin
        if (desc_wr) begin
            desc[wr_seg].req <= mmio.wr_addr[15];
            desc[wr_seg].size <= wr_size;
            desc[wr_seg].addr <= mmio.wr_data;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
    import loader_pkg::*;
#(
    parameter int size_w = loader_pkg::size_w
) (
    input  logic        clk,
    input  logic        rst_n,
    input  desc_t [3:0] desc,
    input  logic        start,
    output dma_rd_req_t dma_req,
    input  dma_rd_rsp_t dma_rsp,
    output logic        beat_valid,
    input  logic        beat_ready,
    output beat_t       beat,
    output segment_t    seg,
    input  logic        unpack_idle,
    output logic        fetch_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_stream,
        st_drain
    } fetch_state_t;

    fetch_state_t      state;
    segment_t          seg_q;
    logic              go_q;
    logic              done_q;
    logic [addr_w-1:0] addr_q;
    logic [size_w-1:0] size_q;
    logic              seg_req;
    logic              seg_last;
    logic              pop;

    // An empty request has nothing to fetch
    assign seg_req = desc[seg_q].req && (desc[seg_q].size != '0);
    assign seg_last = (seg_q == seg_tri);

    // Pop only when the unpacker takes the beat
    assign beat_valid = (state == st_stream) && !dma_rsp.empty;
    assign pop = beat_valid && beat_ready;
    assign beat = dma_rsp.data;
    assign seg = seg_q;

    assign dma_req.go = go_q;
    assign dma_req.pop = pop;
    assign dma_req.addr = addr_q;
    assign dma_req.size = size_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            seg_q <= seg_cp;
            go_q <= 1'b0;
            done_q <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            go_q <= 1'b0;
            fetch_done <= 1'b0;
            if (dma_rsp.done) begin
                done_q <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (start) begin
                        seg_q <= seg_cp;
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    done_q <= 1'b0;
                    if (seg_req) begin
                        go_q <= 1'b1;
                        state <= st_stream;
                    end else if (seg_last) begin
                        fetch_done <= 1'b1;
                        state <= st_idle;
                    end else begin
                        seg_q <= segment_t'(seg_q + 2'd1);
                    end
                end
                st_stream: begin
                    if (done_q) begin
                        state <= st_drain;
                    end
                end
                default: begin
                    // Last beat still being written out
                    if (unpack_idle) begin
                        if (seg_last) begin
                            fetch_done <= 1'b1;
                            state <= st_idle;
                        end else begin
                            seg_q <= segment_t'(seg_q + 2'd1);
                            state <= st_issue;
                        end
                    end
                end
            endcase
        end
    end

    // Request fields stay put for the whole transfer
    always_ff @(posedge clk) begin
        if (state == st_issue && seg_req) begin
            addr_q <= desc[seg_q].addr;
            size_q <= desc[seg_q].size;
        end
    end

endmodule

`default_nettype wire

// File: design/beat_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module beat_unpacker
    import loader_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     beat_valid,
    output logic     beat_ready,
    input  beat_t    beat,
    input  segment_t seg,
    input  logic     rdy_tri,
    output logic     idle,
    output mem_wr_t  mem_wr
);

    localparam int cnt_w = $clog2(words_per_beat + 1);

    beat_t            beat_q;
    segment_t         seg_q;
    logic [cnt_w-1:0] count_q;
    logic             active;
    logic             wr_fire;
    logic             load;

    assign active = (count_q != '0);

    // TRI quads wait for the triangle memory
    assign wr_fire = active && ((seg_q != seg_tri) || rdy_tri);

    // Free now, or freed by the last write this cycle
    assign beat_ready = !active || (wr_fire && (count_q == cnt_w'(1)));
    assign load = beat_valid && beat_ready;
    assign idle = !active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (load) begin
            if (seg == seg_tri) begin
                count_q <= cnt_w'(quads_per_beat);
            end else begin
                count_q <= cnt_w'(words_per_beat);
            end
        end else if (wr_fire) begin
            count_q <= count_q - cnt_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            beat_q <= beat;
            seg_q <= seg;
        end else if (wr_fire) begin
            // Next lane moves into position 0
            if (seg_q == seg_tri) begin
                beat_q <= beat_q >> quad_w;
            end else begin
                beat_q <= beat_q >> word_w;
            end
        end
    end

    assign mem_wr.we = wr_fire ? (4'b0001 << seg_q) : 4'b0000;
    assign mem_wr.data_32 = beat_q.words[0];
    assign mem_wr.data_128 = beat_q.quads[0];

endmodule

`default_nettype wire

// File: design/dma_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_loader_top
    import loader_pkg::*;
#(
    parameter int size_w = loader_pkg::size_w
) (
    input  logic        clk,
    input  logic        rst_n,
    input  mmio_wr_t    mmio,
    output dma_rd_req_t dma_req,
    input  dma_rd_rsp_t dma_rsp,
    input  logic        rdy_tri,
    output mem_wr_t     mem_wr,
    output logic        compute_start
);

    desc_t [3:0] desc;
    logic        start;
    logic        fetch_done;
    logic        beat_valid;
    logic        beat_ready;
    logic        unpack_idle;
    beat_t       beat;
    segment_t    seg;

    desc_regs #(
        .size_w(size_w)
    ) u_desc_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .mmio      (mmio),
        .fetch_done(fetch_done),
        .desc      (desc),
        .start     (start)
    );

    fetch_sequencer #(
        .size_w(size_w)
    ) u_fetch_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .desc       (desc),
        .start      (start),
        .dma_req    (dma_req),
        .dma_rsp    (dma_rsp),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat       (beat),
        .seg        (seg),
        .unpack_idle(unpack_idle),
        .fetch_done (fetch_done)
    );

    beat_unpacker u_beat_unpacker (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat_valid(beat_valid),
        .beat_ready(beat_ready),
        .beat      (beat),
        .seg       (seg),
        .rdy_tri   (rdy_tri),
        .idle      (unpack_idle),
        .mem_wr    (mem_wr)
    );

    // Compute may start once every segment is in local memory
    assign compute_start = fetch_done;

endmodule

`default_nettype wire

// File: dv/host_dma_model.sv
`timescale 1ns/1ps
`default_nettype none

module host_dma_model
    import loader_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dma_rd_req_t dma_req,
    output dma_rd_rsp_t dma_rsp
);

    logic [19:0] lfsr;
    logic [63:0] addr;
    int          size;
    int          beat_idx;
    int          gap;
    logic        busy;

    // x^20 + x^17 + 1
    function automatic logic [19:0] lfsr_step(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    function automatic beat_t make_beat(input logic [31:0] base, input int b);
        beat_t bt;
        for (int l = 0; l < words_per_beat; l++) begin
            bt.words[l] = base + 32'(b * 16 + l);
        end
        return bt;
    endfunction

    // Two LFSR bits give 0 to 3 empty cycles
    task automatic next_gap();
        lfsr = lfsr_step(lfsr);
        gap = lfsr[0];
        lfsr = lfsr_step(lfsr);
        gap = gap * 2 + lfsr[0];
        dma_rsp.empty = (gap != 0);
        dma_rsp.data = make_beat(addr[31:0], beat_idx);
    endtask

    initial begin
        dma_rd_req_t req;
        lfsr = 20'd79856;
        busy = 1'b0;
        dma_rsp = '0;
        dma_rsp.empty = 1'b1;
        forever begin
            @(posedge clk);
            req = dma_req;
            #1;
            dma_rsp.done = 1'b0;
            if (!rst_n) begin
                busy = 1'b0;
                dma_rsp.empty = 1'b1;
            end else if (req.go) begin
                addr = req.addr;
                size = req.size;
                beat_idx = 0;
                busy = 1'b1;
                next_gap();
            end else if (busy && req.pop && !dma_rsp.empty) begin
                beat_idx++;
                if (beat_idx == size) begin
                    busy = 1'b0;
                    dma_rsp.empty = 1'b1;
                    dma_rsp.done = 1'b1;
                end else begin
                    next_gap();
                end
            end else if (busy && dma_rsp.empty) begin
                gap--;
                dma_rsp.empty = (gap > 0);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_dma_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_loader
    import loader_pkg::*;
();

    localparam int n_rows = 4;
    localparam int timeout_cycles = 4000;

    logic        clk;
    logic        rst_n;
    logic        rdy_tri;
    logic        compute_start;
    mmio_wr_t    mmio;
    dma_rd_req_t dma_req;
    dma_rd_rsp_t dma_rsp;
    mem_wr_t     mem_wr;

    // Stimulus table, one row per test; bit s of row_req is segment s
    string       row_name [n_rows];
    logic [3:0]  row_req  [n_rows];
    int          row_size [n_rows][4];
    logic [63:0] row_addr [n_rows][4];
    logic        row_rand [n_rows];

    logic [131:0] exp_q[$];
    logic [131:0] got_q[$];
    // DMA requests as address over size
    logic [76:0]  exp_req_q[$];
    logic [76:0]  got_req_q[$];
    logic [19:0]  lfsr;
    logic         cur_rand;
    logic         quiet;
    int           cur_row;
    int           errors;
    int           passed;
    int           starts;
    int           writes_at_start;

    dma_loader_top #(
        .size_w(size_w)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio         (mmio),
        .dma_req      (dma_req),
        .dma_rsp      (dma_rsp),
        .rdy_tri      (rdy_tri),
        .mem_wr       (mem_wr),
        .compute_start(compute_start)
    );

    host_dma_model host (
        .clk    (clk),
        .rst_n  (rst_n),
        .dma_req(dma_req),
        .dma_rsp(dma_rsp)
    );

    function automatic logic [19:0] lfsr_step(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        if (cur_rand) begin
            lfsr = lfsr_step(lfsr);
            rdy_tri = lfsr[0];
        end else begin
            rdy_tri = 1'b1;
        end
    end

    // Monitor for local-memory writes, DMA requests and compute_start
    always @(posedge clk) begin
        if (quiet && (dma_req.go || dma_req.pop || mem_wr.we != 4'b0000 || compute_start)) begin
            errors++;
            $display("DUT output active before any descriptor was written");
        end
        if (dma_req.go) begin
            got_req_q.push_back({dma_req.addr, dma_req.size});
        end
        if (mem_wr.we[3]) begin
            if (!rdy_tri) begin
                errors++;
                $display("%s: TRI write while the triangle memory was not ready",
                         row_name[cur_row]);
            end
            got_q.push_back({mem_wr.we, mem_wr.data_128});
        end else if (mem_wr.we != 4'b0000) begin
            got_q.push_back({mem_wr.we, 96'd0, mem_wr.data_32});
        end
        if (compute_start) begin
            starts++;
            writes_at_start = got_q.size();
        end
    end

    task automatic set_row(input int r, input string name, input logic [3:0] req,
                           input int s1, input int s2, input int s3,
                           input logic [63:0] base, input logic rnd);
        row_name[r] = name;
        row_req[r] = req;
        // CP size bits are ignored by the DUT
        row_size[r][0] = 5;
        row_size[r][1] = s1;
        row_size[r][2] = s2;
        row_size[r][3] = s3;
        for (int s = 0; s < 4; s++) begin
            row_addr[r][s] = base + 64'(s) * 64'h10_0040;
        end
        row_rand[r] = rnd;
    endtask

    task automatic build_expected(input int r);
        logic [31:0] lane [words_per_beat];
        int          n;
        exp_q.delete();
        exp_req_q.delete();
        for (int s = 0; s < 4; s++) begin
            n = (s == 0) ? 1 : row_size[r][s];
            if (row_req[r][s]) begin
                exp_req_q.push_back({row_addr[r][s], 13'(n)});
            end
            for (int b = 0; b < n && row_req[r][s]; b++) begin
                for (int l = 0; l < words_per_beat; l++) begin
                    lane[l] = row_addr[r][s][31:0] + 32'(b * 16 + l);
                end
                for (int l = 0; l < words_per_beat && s < 3; l++) begin
                    exp_q.push_back({4'(1 << s), 96'd0, lane[l]});
                end
                for (int q = 0; q < quads_per_beat && s == 3; q++) begin
                    exp_q.push_back({4'b1000, lane[4*q+3], lane[4*q+2],
                                     lane[4*q+1], lane[4*q]});
                end
            end
        end
    endtask

    task automatic mmio_write(input logic req, input int size, input logic [1:0] low,
                              input logic [63:0] data);
        @(posedge clk);
        #1;
        mmio.wr_en = 1'b1;
        mmio.wr_addr = {req, 13'(size), low};
        mmio.wr_data = data;
        @(posedge clk);
        #1;
        mmio.wr_en = 1'b0;
    endtask

    task automatic run_row(input int r);
        int cycles;
        int err_before;
        err_before = errors;
        cur_row = r;
        cur_rand = row_rand[r];
        build_expected(r);
        got_q.delete();
        got_req_q.delete();
        starts = 0;
        writes_at_start = -1;
        quiet = 1'b0;
        for (int s = 0; s < 4; s++) begin
            mmio_write(row_req[r][s], row_size[r][s], 2'b00, row_addr[r][s]);
        end
        cycles = 0;
        while (starts == 0 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (starts == 0) begin
            $display("%s: compute_start did not arrive in time", row_name[r]);
            $display("Done: errors found");
            $finish;
        end
        // Let any late write or second pulse show up
        repeat (8) @(negedge clk);
        if (starts != 1) begin
            errors++;
            $display("[ERROR] %s: compute_start pulses expected 1 actual %0d",
                     row_name[r], starts);
        end
        if (got_q.size() != writes_at_start) begin
            errors++;
            $display("%s: local-memory writes came after compute_start", row_name[r]);
        end
        if (got_req_q.size() != exp_req_q.size()) begin
            errors++;
            $display("[ERROR] %s: DMA request count expected %0d actual %0d",
                     row_name[r], exp_req_q.size(), got_req_q.size());
        end
        for (int i = 0; i < exp_req_q.size() && i < got_req_q.size(); i++) begin
            if (got_req_q[i] !== exp_req_q[i]) begin
                errors++;
                $display("[ERROR] %s: DMA request %0d expected %h actual %h",
                         row_name[r], i, exp_req_q[i], got_req_q[i]);
            end
        end
        if (got_q.size() != exp_q.size()) begin
            errors++;
            $display("[ERROR] %s: write count expected %0d actual %0d",
                     row_name[r], exp_q.size(), got_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            if (got_q[i] !== exp_q[i]) begin
                errors++;
                $display("[ERROR] %s: write %0d expected %h actual %h",
                         row_name[r], i, exp_q[i], got_q[i]);
            end
        end
        if (errors == err_before) begin
            passed++;
        end
        $display("%s: %s, %0d writes", row_name[r],
                 (errors == err_before) ? "pass" : "FAIL", got_q.size());
    endtask

    initial begin
        rst_n = 1'b0;
        rdy_tri = 1'b1;
        mmio = '0;
        lfsr = 20'd79856;
        cur_rand = 1'b0;
        quiet = 1'b1;
        cur_row = 0;
        errors = 0;
        passed = 0;
        set_row(0, "all_segments", 4'b1111, 3, 2, 2, 64'h0000_00a0_1000_0000, 1'b0);
        set_row(1, "skip_rt_const", 4'b1001, 4, 4, 2, 64'h0000_0003_2000_0100, 1'b0);
        set_row(2, "tri_backpressure", 4'b1111, 1, 1, 3, 64'h0000_0000_7000_0800, 1'b1);
        set_row(3, "skip_tri", 4'b0111, 2, 1, 4, 64'h0000_0012_0abc_0000, 1'b1);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);
        // Bit 1 set, so this must not be taken as the CP descriptor
        mmio_write(1'b1, 1, 2'b10, 64'h0000_0000_dead_0000);
        repeat (3) @(posedge clk);
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 n_rows, passed, n_rows - passed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/loader_pkg.sv
design/desc_regs.sv
design/fetch_sequencer.sv
design/beat_unpacker.sv
design/dma_loader_top.sv
dv/host_dma_model.sv
dv/tb_dma_loader.sv
